/* compile.f */
verilog/conv_geom_pkg.sv
verilog/conv_data_pkg.sv
verilog/feature_ram.sv
verilog/feature_replay_buffer.sv
verilog/pointwise_mac.sv
verilog/pointwise_conv_top.sv
verif/pointwise_conv_properties.sv
verif/pointwise_conv_tb.sv

/* Makefile */
SIM       = verilator
SIM_FLAGS = --binary --timing --assert
TOP       = pointwise_conv_tb
FILELIST  = compile.f
BUILD_DIR = obj_dir
LOG       = sim.log
FAIL_MSG  = Finished with errors

BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

# An aborted run also counts as a failure
test:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BIN) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verif/pointwise_conv_tb.sv */
`timescale 1ns/10ps

module pointwise_conv_tb
	import conv_geom_pkg::*, conv_data_pkg::*;
();

	localparam int IMAGE_WIDTH = DEF_IMAGE_WIDTH;
	localparam int CH_IN = DEF_CH_IN;
	localparam int CH_OUT = DEF_CH_OUT;
	localparam int PIXELS = IMAGE_WIDTH * IMAGE_WIDTH;
	localparam int FRAME_WORDS = frame_words(IMAGE_WIDTH, CH_IN);
	localparam int RESULTS = CH_OUT * PIXELS;
	localparam int SEED = 32'h1253fcb0;
	localparam int BUSY_TIMEOUT = 1000;
	localparam int DRAIN_TIMEOUT = 20;
	localparam int QUIET_CYCLES = 20;

	logic    clk;
	logic    reset;
	logic    wgt_valid;
	weight_t wgt_data;
	logic    pxl_valid;
	pixel_t  pxl_data;
	logic    out_valid;
	acc_t    out_data;
	logic    busy;

	// Reference model state
	weight_t wgt_model [CH_OUT][CH_IN];
	pixel_t  frame [FRAME_WORDS];
	acc_t    exp_q [$];

	int errors;
	int checks;
	int result_cnt;

	pointwise_conv_top UUT (
		.clk      (clk),
		.reset    (reset),
		.wgt_valid(wgt_valid),
		.wgt_data (wgt_data),
		.pxl_valid(pxl_valid),
		.pxl_data (pxl_data),
		.out_valid(out_valid),
		.out_data (out_data),
		.busy     (busy)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	//////////////////////////////////////////////////
	// Result collector

	always @(posedge clk) begin
		acc_t expected;
		if (!reset && out_valid) begin
			result_cnt++;
			checks++;
			assert (exp_q.size() > 0) else begin
				$display("Result on out_data arrived with no result expected");
				errors++;
			end
			if (exp_q.size() > 0) begin
				expected = exp_q.pop_front();
				assert (out_data == expected) else begin
					$display("Fail out_data: got 0x%h, expected 0x%h", out_data, expected);
					errors++;
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// Stimulus and model

	// Output-channel-major and input-channel-minor order
	task automatic load_weights(input bit extreme);
		weight_t w;
		for (int oc = 0; oc < CH_OUT; oc++) begin
			for (int ic = 0; ic < CH_IN; ic++) begin
				if (extreme) begin
					w = ((oc + ic) % 2 == 0) ? weight_t'(-128) : weight_t'(127);
				end else begin
					w = weight_t'($urandom);
				end
				wgt_model[oc][ic] = w;
				@(posedge clk);
				wgt_valid <= 1'b1;
				wgt_data <= w;
			end
		end
		@(posedge clk);
		wgt_valid <= 1'b0;
	endtask

	task automatic fill_frame(input bit saturate);
		for (int i = 0; i < FRAME_WORDS; i++) begin
			frame[i] = saturate ? pixel_t'(255) : pixel_t'($urandom);
		end
	endtask

	// Signed dot products in output-channel then pixel order
	task automatic build_expected();
		int sum;
		for (int oc = 0; oc < CH_OUT; oc++) begin
			for (int px = 0; px < PIXELS; px++) begin
				sum = 0;
				for (int ic = 0; ic < CH_IN; ic++) begin
					sum += int'(frame[px * CH_IN + ic]) * int'(wgt_model[oc][ic]);
				end
				exp_q.push_back(acc_t'(sum));
			end
		end
	endtask

	task automatic send_frame(input int max_gap);
		int gap;
		for (int i = 0; i < FRAME_WORDS; i++) begin
			gap = (max_gap > 0) ? int'($urandom_range(0, max_gap)) : 0;
			repeat (gap) begin
				@(posedge clk);
				pxl_valid <= 1'b0;
			end
			@(posedge clk);
			pxl_valid <= 1'b1;
			pxl_data <= frame[i];
		end
		@(posedge clk);
		pxl_valid <= 1'b0;
	endtask

	task automatic wait_busy_low();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (busy && cycles < BUSY_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (busy) begin
			$display("Timeout: busy still high after %0d cycles", BUSY_TIMEOUT);
			errors++;
		end
	endtask

	task automatic wait_results_drained();
		int cycles;
		cycles = 0;
		while (exp_q.size() > 0 && cycles < DRAIN_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (exp_q.size() > 0) begin
			$display("Timeout: %0d expected results never arrived", exp_q.size());
			errors++;
			exp_q.delete();
		end
	endtask

	task automatic run_frame(input int max_gap);
		build_expected();
		send_frame(max_gap);
		wait_busy_low();
		wait_results_drained();
	endtask

	task automatic report_test(input int num, input string name, input int err_start);
		$display("Test %0d %s: %0d errors", num, name, errors - err_start);
	endtask

	//////////////////////////////////////////////////
	// Directed tests

	initial begin
		int err_start;
		int start_cnt;
		void'($urandom(SEED));
		reset = 1'b1;
		wgt_valid = 1'b0;
		wgt_data = '0;
		pxl_valid = 1'b0;
		pxl_data = '0;
		errors = 0;
		checks = 0;
		result_cnt = 0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;

		err_start = errors;
		load_weights(1'b0);
		fill_frame(1'b0);
		run_frame(0);
		report_test(1, "random frame back to back", err_start);

		// Same weights and data as the gap-free frame
		err_start = errors;
		run_frame(3);
		report_test(2, "frame with input gaps", err_start);

		err_start = errors;
		load_weights(1'b1);
		fill_frame(1'b1);
		run_frame(0);
		report_test(3, "extreme values", err_start);

		// Last result is still in the MAC when busy falls
		err_start = errors;
		start_cnt = result_cnt;
		fill_frame(1'b0);
		build_expected();
		send_frame(0);
		wait_busy_low();
		checks++;
		assert (result_cnt - start_cnt == RESULTS - 1) else begin
			$display("Fail result count at busy fall: got 0x%0h, expected 0x%0h",
				result_cnt - start_cnt, RESULTS - 1);
			errors++;
		end
		wait_results_drained();
		repeat (QUIET_CYCLES) @(negedge clk);
		checks++;
		assert (result_cnt - start_cnt == RESULTS) else begin
			$display("Fail result count: got 0x%0h, expected 0x%0h",
				result_cnt - start_cnt, RESULTS);
			errors++;
		end
		report_test(4, "frame completion", err_start);

		err_start = errors;
		load_weights(1'b0);
		fill_frame(1'b0);
		run_frame(0);
		report_test(5, "second frame with new weights", err_start);

		$display("Tests run: 5, checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

/* verif/pointwise_conv_properties.sv */
`timescale 1ns/10ps

module pointwise_conv_properties
	import conv_geom_pkg::*;
#(
	parameter int IMAGE_WIDTH = DEF_IMAGE_WIDTH,
	parameter int CH_IN = DEF_CH_IN
) (
	input logic clk,
	input logic reset,
	input logic wgt_valid,
	input logic pxl_valid,
	input logic out_valid,
	input logic busy
);

	localparam int FRAME_WORDS = frame_words(IMAGE_WIDTH, CH_IN);
	localparam int TAKEN_BITS = cnt_bits(FRAME_WORDS + 1);

	// Input words taken in the current frame
	logic [TAKEN_BITS-1:0] taken;
	logic frame_full;

	assign frame_full = (taken == TAKEN_BITS'(FRAME_WORDS));

	always_ff @(posedge clk) begin
		if (reset) begin
			taken <= '0;
		end else if (!busy) begin
			taken <= pxl_valid ? TAKEN_BITS'(1) : '0;
		end else if (pxl_valid && !frame_full) begin
			taken <= taken + 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// Protocol

	// Further input is dropped once the whole frame is stored
	a_no_pxl_in_replay: assert property (@(posedge clk) disable iff (reset)
		busy && frame_full |-> !pxl_valid)
		else $error("pxl_valid high after the frame was complete");

	a_reset_quiet: assert property (@(posedge clk)
		reset |=> !out_valid && !busy)
		else $error("out_valid or busy high right after reset");

	a_no_wgt_busy: assert property (@(posedge clk) disable iff (reset)
		busy |-> !wgt_valid)
		else $error("wgt_valid high while busy");

endmodule

bind pointwise_conv_top pointwise_conv_properties #(
	.IMAGE_WIDTH(IMAGE_WIDTH),
	.CH_IN      (CH_IN)
) u_properties (
	.clk      (clk),
	.reset    (reset),
	.wgt_valid(wgt_valid),
	.pxl_valid(pxl_valid),
	.out_valid(out_valid),
	.busy     (busy)
);

/* verilog/pointwise_conv_top.sv */
`timescale 1ns/10ps

module pointwise_conv_top
	import conv_geom_pkg::*, conv_data_pkg::*;
#(
	parameter int IMAGE_WIDTH = DEF_IMAGE_WIDTH,
	parameter int CH_IN = DEF_CH_IN,
	parameter int CH_OUT = DEF_CH_OUT,
	parameter int GAP_CYCLES = DEF_GAP_CYCLES
) (
	input  logic    clk,
	input  logic    reset,

	// Weight load while idle only
	input  logic    wgt_valid,
	input  weight_t wgt_data,

	// Input feature words
	input  logic    pxl_valid,
	input  pixel_t  pxl_data,

	// Results
	output logic    out_valid,
	output acc_t    out_data,

	output logic    busy
);

	//////////////////////////////////////////////////
	// Buffer to MAC stream

	logic   stream_valid;
	pixel_t stream_data;

	feature_replay_buffer #(
		.IMAGE_WIDTH(IMAGE_WIDTH),
		.CH_IN      (CH_IN),
		.CH_OUT     (CH_OUT),
		.GAP_CYCLES (GAP_CYCLES)
	) u_buffer (
		.clk         (clk),
		.reset       (reset),
		.pxl_valid   (pxl_valid),
		.pxl_data    (pxl_data),
		.stream_valid(stream_valid),
		.stream_data (stream_data),
		.busy        (busy)
	);

	// MAC follows the stream order with one pass per output channel
	pointwise_mac #(
		.IMAGE_WIDTH(IMAGE_WIDTH),
		.CH_IN      (CH_IN),
		.CH_OUT     (CH_OUT)
	) u_mac (
		.clk         (clk),
		.reset       (reset),
		.wgt_valid   (wgt_valid),
		.wgt_data    (wgt_data),
		.stream_valid(stream_valid),
		.stream_data (stream_data),
		.out_valid   (out_valid),
		.out_data    (out_data)
	);

endmodule

/* verilog/pointwise_mac.sv */
`timescale 1ns/10ps

module pointwise_mac
	import conv_geom_pkg::*, conv_data_pkg::*;
#(
	parameter int IMAGE_WIDTH = DEF_IMAGE_WIDTH,
	parameter int CH_IN = DEF_CH_IN,
	parameter int CH_OUT = DEF_CH_OUT
) (
	input  logic    clk,
	input  logic    reset,
	input  logic    wgt_valid,
	input  weight_t wgt_data,
	input  logic    stream_valid,
	input  pixel_t  stream_data,
	output logic    out_valid,
	output acc_t    out_data
);

	localparam int FRAME_WORDS = frame_words(IMAGE_WIDTH, CH_IN);
	localparam int WGT_WORDS = CH_IN * CH_OUT;
	localparam int WADDR_BITS = cnt_bits(WGT_WORDS);
	localparam int WORD_BITS = cnt_bits(FRAME_WORDS);
	localparam int IC_BITS = cnt_bits(CH_IN);
	localparam int OC_BITS = cnt_bits(CH_OUT);

	if (CH_IN > MAX_ACC_TERMS) begin : g_ch_in_check
		$error("CH_IN exceeds the accumulator headroom");
	end

	logic [WADDR_BITS-1:0] load_addr;
	logic [WADDR_BITS-1:0] rd_addr;
	logic [WADDR_BITS-1:0] wgt_addr;

	logic [WORD_BITS-1:0] word_cnt;
	logic [IC_BITS-1:0]   ic_cnt;
	logic [OC_BITS-1:0]   oc_cnt;

	weight_t wgt_q;
	pixel_t  px_d;
	logic    valid_d;
	logic    first_d;
	logic    last_d;

	logic signed [PIXEL_BITS:0] px_s;
	prod_t prod;
	acc_t  acc_base;
	acc_t  acc;

	//////////////////////////////////////////////////
	// Weight store

	// One row per output channel with a column per input channel
	assign rd_addr = WADDR_BITS'(oc_cnt * CH_IN + ic_cnt);
	assign wgt_addr = wgt_valid ? load_addr : rd_addr;

	always_ff @(posedge clk) begin
		if (reset) begin
			load_addr <= '0;
		end else if (wgt_valid) begin
			if (load_addr == WADDR_BITS'(WGT_WORDS - 1)) begin
				load_addr <= '0;
			end else begin
				load_addr <= load_addr + 1'b1;
			end
		end
	end

	feature_ram #(
		.DEPTH (WGT_WORDS),
		.word_t(weight_t)
	) u_weight_ram (
		.clk (clk),
		.en  (wgt_valid || stream_valid),
		.we  (wgt_valid),
		.addr(wgt_addr),
		.din (wgt_data),
		.dout(wgt_q)
	);

	//////////////////////////////////////////////////
	// Stream position tracking

	always_ff @(posedge clk) begin
		if (reset) begin
			word_cnt <= '0;
			ic_cnt <= '0;
			oc_cnt <= '0;
		end else if (stream_valid) begin
			if (ic_cnt == IC_BITS'(CH_IN - 1)) begin
				ic_cnt <= '0;
			end else begin
				ic_cnt <= ic_cnt + 1'b1;
			end

			// End of one pass moves to the next output channel
			if (word_cnt == WORD_BITS'(FRAME_WORDS - 1)) begin
				word_cnt <= '0;
				if (oc_cnt == OC_BITS'(CH_OUT - 1)) begin
					oc_cnt <= '0;
				end else begin
					oc_cnt <= oc_cnt + 1'b1;
				end
			end else begin
				word_cnt <= word_cnt + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////
	// Multiply-accumulate

	// Pixel waits one cycle for the registered weight
	always_ff @(posedge clk) begin
		if (reset) begin
			valid_d <= 1'b0;
			first_d <= 1'b0;
			last_d <= 1'b0;
		end else begin
			valid_d <= stream_valid;
			first_d <= (ic_cnt == '0);
			last_d <= (ic_cnt == IC_BITS'(CH_IN - 1));
		end
	end

	always_ff @(posedge clk) begin
		px_d <= stream_data;
	end

	// Zero-extend so the unsigned pixel multiplies as signed
	assign px_s = {1'b0, px_d};
	assign prod = px_s * wgt_q;
	assign acc_base = first_d ? '0 : acc;

	always_ff @(posedge clk) begin
		if (valid_d) begin
			acc <= acc_base + prod;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= valid_d && last_d;
		end
	end

	assign out_data = acc;

endmodule

/* verilog/feature_replay_buffer.sv */
`timescale 1ns/10ps

module feature_replay_buffer
	import conv_geom_pkg::*, conv_data_pkg::*;
#(
	parameter int IMAGE_WIDTH = DEF_IMAGE_WIDTH,
	parameter int CH_IN = DEF_CH_IN,
	parameter int CH_OUT = DEF_CH_OUT,
	parameter int GAP_CYCLES = DEF_GAP_CYCLES
) (
	input  logic   clk,
	input  logic   reset,
	input  logic   pxl_valid,
	input  pixel_t pxl_data,
	output logic   stream_valid,
	output pixel_t stream_data,
	output logic   busy
);

	localparam int FRAME_WORDS = frame_words(IMAGE_WIDTH, CH_IN);
	localparam int ADDR_BITS = cnt_bits(FRAME_WORDS);
	localparam int GAP_BITS = cnt_bits(GAP_CYCLES);
	localparam int PASS_BITS = cnt_bits(CH_OUT);

	typedef enum logic [1:0] {
		S_IDLE,
		S_FILL,
		S_GAP,
		S_REPLAY
	} state_t;

	state_t state;

	logic [ADDR_BITS-1:0] addr_cnt;
	logic [GAP_BITS-1:0]  gap_cnt;
	logic [PASS_BITS-1:0] pass_cnt;

	// High for the cycle that carries the final word of a frame
	logic drain;

	logic accept;
	logic reading;
	logic ram_en;
	logic pass_end;
	logic last_pass;

	pixel_t ram_dout;
	pixel_t fwd_data;
	logic   from_ram;

	//////////////////////////////////////////////////
	// Control decode

	// Pixels only count while idle or filling
	assign accept = pxl_valid && (((state == S_IDLE) && !drain) || (state == S_FILL));
	assign reading = (state == S_REPLAY);
	assign ram_en = accept || reading;

	assign pass_end = ram_en && (addr_cnt == ADDR_BITS'(FRAME_WORDS - 1));
	assign last_pass = (pass_cnt == PASS_BITS'(CH_OUT - 1));

	assign busy = (state != S_IDLE) || drain;

	// Pass 0 forwards the live word and replay passes take the RAM word
	assign stream_data = from_ram ? ram_dout : fwd_data;

	//////////////////////////////////////////////////
	// FSM and counters

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_IDLE;
			addr_cnt <= '0;
			gap_cnt <= '0;
			pass_cnt <= '0;
			drain <= 1'b0;
		end else begin
			drain <= 1'b0;

			if (ram_en) begin
				if (pass_end) begin
					addr_cnt <= '0;
					if (last_pass) begin
						// Frame done and the last word leaves next cycle
						state <= S_IDLE;
						pass_cnt <= '0;
						drain <= 1'b1;
					end else begin
						state <= S_GAP;
						pass_cnt <= pass_cnt + 1'b1;
					end
				end else begin
					addr_cnt <= addr_cnt + 1'b1;
					if (state == S_IDLE) begin
						state <= S_FILL;
					end
				end
			end

			if (state == S_GAP) begin
				if (gap_cnt == GAP_BITS'(GAP_CYCLES - 1)) begin
					gap_cnt <= '0;
					state <= S_REPLAY;
				end else begin
					gap_cnt <= gap_cnt + 1'b1;
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// Output stream

	// One cycle behind the write in pass 0 and behind the read in replay
	always_ff @(posedge clk) begin
		if (reset) begin
			stream_valid <= 1'b0;
			from_ram <= 1'b0;
		end else begin
			stream_valid <= ram_en;
			from_ram <= reading;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			fwd_data <= pxl_data;
		end
	end

	feature_ram #(
		.DEPTH (FRAME_WORDS),
		.word_t(pixel_t)
	) u_frame_ram (
		.clk (clk),
		.en  (ram_en),
		.we  (accept),
		.addr(addr_cnt),
		.din (pxl_data),
		.dout(ram_dout)
	);

endmodule

/* verilog/feature_ram.sv */
`timescale 1ns/10ps

module feature_ram
	import conv_geom_pkg::*;
#(
	parameter int DEPTH = 16,
	parameter type word_t = logic [7:0]
) (
	input  logic                       clk,
	input  logic                       en,
	input  logic                       we,
	input  logic [cnt_bits(DEPTH)-1:0] addr,
	input  word_t                      din,
	output word_t                      dout
);

	word_t mem [DEPTH];

	// Read-first so dout returns the old contents on a write
	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				mem[addr] <= din;
			end
			dout <= mem[addr];
		end
	end

endmodule

/* verilog/conv_data_pkg.sv */
package conv_data_pkg;

	//////////////////////////////////////////////////
	// Word widths

	localparam int PIXEL_BITS = 8;
	localparam int WEIGHT_BITS = 8;

	// Unsigned 8-bit pixel times signed 8-bit weight fits in 16 signed bits
	localparam int PROD_BITS = PIXEL_BITS + WEIGHT_BITS;

	// Headroom for summing products over the input channels
	localparam int ACC_GUARD_BITS = 4;
	localparam int ACC_BITS = PROD_BITS + ACC_GUARD_BITS;

	// Largest channel count the accumulator can sum without overflow
	localparam int MAX_ACC_TERMS = 2 ** ACC_GUARD_BITS;

	//////////////////////////////////////////////////
	// Data types

	// Unsigned feature word
	typedef logic [PIXEL_BITS-1:0] pixel_t;

	// Two's complement filter weight
	typedef logic signed [WEIGHT_BITS-1:0] weight_t;

	// Single product
	typedef logic signed [PROD_BITS-1:0] prod_t;

	// Accumulator and output word
	typedef logic signed [ACC_BITS-1:0] acc_t;

endpackage

/* verilog/conv_geom_pkg.sv */
package conv_geom_pkg;

	//////////////////////////////////////////////////
	// Layer geometry defaults

	// Side of the square input image
	localparam int DEF_IMAGE_WIDTH = 4;
	// Channels per input pixel
	localparam int DEF_CH_IN = 3;
	// Output channels and so passes per frame
	localparam int DEF_CH_OUT = 4;
	// Idle cycles between passes
	localparam int DEF_GAP_CYCLES = 5;

	//////////////////////////////////////////////////
	// Derived sizes

	// Words in one stored frame
	function automatic int frame_words(int image_width, int ch_in);
		return image_width * image_width * ch_in;
	endfunction

	// Counter or address width for values 0 .. count-1
	function automatic int cnt_bits(int count);
		if (count > 2) begin
			return $clog2(count);
		end
		return 1;
	endfunction

endpackage
